//--- src/adder_pkg.sv
//**************************************
// fixed 8-bit datapath with a 16-bit command word
// reserved configuration bits are ignored by the hardware
//**************************************
`default_nettype none

package adder_pkg;

  // operand and command widths, fixed for this unit
  localparam int data_w = 8;
  localparam int cmd_w  = 16;

  // command kind that travels next to each strobe
  localparam logic cmd_kind_op  = 1'b0;
  localparam logic cmd_kind_cfg = 1'b1;

  // operand view of the command word, a in the high byte
  typedef struct packed {
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
  } operand_pair_t;

  // configuration view of the command word
  // four steering bits sit at the bottom, the rest is reserved
  typedef struct packed {
    logic [cmd_w-5:0] reserved;
    logic             carry_in;
    logic             sub;
    logic             cin_en;
    logic             sat;
  } cfg_fields_t;

  // one input word, read as operands or as a config write by kind
  typedef union packed {
    operand_pair_t ops;
    cfg_fields_t   cfg;
  } cmd_word_u;

  // live configuration driven by the register block
  typedef struct packed {
    logic sub;
    logic cin_en;
    logic carry_in;
    logic sat;
  } adder_cfg_t;

  // registered result with flags
  // carry means no borrow in subtract mode
  typedef struct packed {
    logic [data_w-1:0] sum;
    logic              carry;
    logic              ovf;
  } adder_res_t;

endpackage

`default_nettype wire

//--- src/pg_carry_adder.sv
//**************************************
// combinational, zero latency
// clk only samples the carry-chain checks
//**************************************
`default_nettype none

module pg_carry_adder
  import adder_pkg::*;
(
  input  logic              clk,
  input  logic [data_w-1:0] a,
  input  logic [data_w-1:0] b,
  input  logic              cin,
  output logic [data_w-1:0] sum,
  output logic              cout
);

  // per-bit propagate and generate
  logic [data_w-1:0] p;
  logic [data_w-1:0] g;

  // carry into bit i, index data_w is the carry out
  logic [data_w:0] c_rip;
  logic [data_w:0] c_pred;

  assign p = a ^ b;
  assign g = a & b;

  // reference ripple path, one bit feeds the next
  always_comb begin
    c_rip[0] = cin;
    for (int i = 0; i < data_w; i++) begin
      c_rip[i+1] = g[i] | (p[i] & c_rip[i]);
    end
  end

  // lookahead prediction, each carry as a flat sum of products
  // walk down from bit i and keep the running propagate product
  always_comb begin : lookahead_b
    logic term;
    logic pchain;
    c_pred[0] = cin;
    for (int i = 0; i < data_w; i++) begin
      term   = 1'b0;
      pchain = 1'b1;
      for (int j = i; j >= 0; j--) begin
        // g[j] only counts if every bit above it up to i propagates
        term   = term | (pchain & g[j]);
        pchain = pchain & p[j];
      end
      // carry-in survives only a full propagate chain from bit 0
      c_pred[i+1] = term | (pchain & cin);
    end
  end

  // sum uses the predicted carries, not the ripple ones
  assign sum  = p ^ c_pred[data_w-1:0];
  assign cout = c_pred[data_w];

  // predicted chain must agree with the ripple chain at every bit
  a_carry_pred: assert property (
    @(posedge clk) c_pred == c_rip
  ) else $error("pg_carry_adder: predicted carry %h, ripple %h", c_pred, c_rip);

  // end-to-end check of the whole adder against plain arithmetic
  a_sum: assert property (
    @(posedge clk)
      {cout, sum} == ((data_w+1)'(a) + (data_w+1)'(b) + (data_w+1)'(cin))
  ) else $error("pg_carry_adder: %h + %h + %b gave %h", a, b, cin, {cout, sum});

endmodule

`default_nettype wire

//--- src/adder_cfg_regs.sv
//**************************************
// new settings show one cycle after cfg_we
//**************************************
`default_nettype none

module adder_cfg_regs
  import adder_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        cfg_we,
  input  cfg_fields_t cfg_in,
  output adder_cfg_t  cfg
);

  adder_cfg_t cfg_q;

  // reset value is a plain add, no carry-in, no saturation
  // reserved field of cfg_in is dropped here
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg_q <= '0;
    end else if (cfg_we) begin
      cfg_q.sub      <= cfg_in.sub;
      cfg_q.cin_en   <= cfg_in.cin_en;
      cfg_q.carry_in <= cfg_in.carry_in;
      cfg_q.sat      <= cfg_in.sat;
    end
  end

  // straight from the flops so the stage sees a clean snapshot
  assign cfg = cfg_q;

  // settings only move on a write strobe
  a_cfg_hold: assert property (
    @(posedge clk) disable iff (rst)
      !cfg_we |=> $stable(cfg)
  ) else $error("adder_cfg_regs: cfg changed without cfg_we");

endmodule

`default_nettype wire

//--- src/adder_stage.sv
//**************************************
// latency is 2 cycles, no stall, results leave in order
// config is sampled with the operands
//**************************************
`default_nettype none

module adder_stage
  import adder_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  logic          op_valid,
  input  operand_pair_t ops,
  input  adder_cfg_t    cfg,
  output logic          res_valid,
  output adder_res_t    res
);

  // stage 1 holding registers
  logic          s1_valid;
  operand_pair_t s1_ops;
  adder_cfg_t    s1_cfg;

  // conditioned adder inputs and raw outputs
  logic [data_w-1:0] add_b;
  logic              add_cin;
  logic [data_w-1:0] add_sum;
  logic              add_cout;
  logic              ovf;
  adder_res_t        res_d;

  // stage 1, operands plus the config in force at the strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s1_ops   <= '0;
      s1_cfg   <= '0;
    end else begin
      s1_valid <= op_valid;
      if (op_valid) begin
        s1_ops <= ops;
        s1_cfg <= cfg;
      end
    end
  end

  // subtract is a + ~b + 1
  assign add_b   = s1_cfg.sub ? ~s1_ops.b : s1_ops.b;
  assign add_cin = s1_cfg.sub ? 1'b1 : (s1_cfg.cin_en & s1_cfg.carry_in);

  pg_carry_adder adder_i (
    .clk  (clk),
    .a    (s1_ops.a),
    .b    (add_b),
    .cin  (add_cin),
    .sum  (add_sum),
    .cout (add_cout)
  );

  // signed overflow on the conditioned b covers add and subtract alike
  assign ovf = (s1_ops.a[data_w-1] == add_b[data_w-1]) &&
               (add_sum[data_w-1] != s1_ops.a[data_w-1]);

  always_comb begin
    res_d.sum   = add_sum;
    res_d.carry = add_cout;
    res_d.ovf   = ovf;
    // unsigned clamp, flags keep their unsaturated values
    if (s1_cfg.sat) begin
      if (!s1_cfg.sub && add_cout) begin
        res_d.sum = '1;
      end else if (s1_cfg.sub && !add_cout) begin
        // no carry out of a subtract is a borrow
        res_d.sum = '0;
      end
    end
  end

  // stage 2, result register and valid pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
      res       <= '0;
    end else begin
      res_valid <= s1_valid;
      if (s1_valid) begin
        res <= res_d;
      end
    end
  end

  // every result pulse traces back to a strobe two cycles before
  a_res_src: assert property (
    @(posedge clk) disable iff (rst)
      res_valid |-> $past(op_valid, 2)
  ) else $error("adder_stage: res_valid without op_valid two cycles earlier");

  // and every strobe produces one
  a_res_lat: assert property (
    @(posedge clk) disable iff (rst)
      op_valid |-> ##2 res_valid
  ) else $error("adder_stage: op_valid not answered after two cycles");

endmodule

`default_nettype wire

//--- src/adder_top.sv
//**************************************
// one command per strobe, no ready
// res_valid must be taken when it pulses
//**************************************
`default_nettype none

module adder_top
  import adder_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       cmd_valid,
  input  logic       cmd_kind,
  input  cmd_word_u  cmd,
  output logic       res_valid,
  output adder_res_t res,
  output adder_cfg_t cfg
);

  logic cfg_we;
  logic op_valid;

  // kind picks how the same word is read
  assign cfg_we   = cmd_valid && (cmd_kind == cmd_kind_cfg);
  assign op_valid = cmd_valid && (cmd_kind == cmd_kind_op);

  adder_cfg_regs cfg_regs_i (
    .clk    (clk),
    .rst    (rst),
    .cfg_we (cfg_we),
    .cfg_in (cmd.cfg),
    .cfg    (cfg)
  );

  // stage snapshots the port-visible cfg at each operation strobe
  adder_stage stage_i (
    .clk       (clk),
    .rst       (rst),
    .op_valid  (op_valid),
    .ops       (cmd.ops),
    .cfg       (cfg),
    .res_valid (res_valid),
    .res       (res)
  );

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
//****************************************
// free-running clock, period 40
// rst high for the first 4 rising edges
//****************************************
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // release on a falling edge, nonblocking so readers there see the old value
  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- dv/tb_adder_top.sv
//****************************************
// rows are applied back to back, one strobe per cycle
// stops at the first error
//****************************************
`default_nettype none

module tb_adder_top
  import adder_pkg::*;
();

  // one table row, exp_cfg used by config rows, exp_res by operation rows
  typedef struct packed {
    logic       kind;
    cmd_word_u  word;
    adder_cfg_t exp_cfg;
    adder_res_t exp_res;
  } row_t;

  // outstanding operation, tagged with the cycle of its strobe
  typedef struct packed {
    adder_res_t  res;
    logic [31:0] cyc;
  } pend_t;

  logic       clk;
  logic       rst;
  logic       cmd_valid;
  logic       cmd_kind;
  cmd_word_u  cmd;
  logic       res_valid;
  adder_res_t res;
  adder_cfg_t cfg;

  row_t        rows[$];
  pend_t       pend_q[$];
  logic [31:0] cyc = '0;
  logic [31:0] rng_state;
  int          n_ops;
  int          n_checked;
  logic        cfg_pending;
  adder_cfg_t  cfg_exp;

  tb_clk_gen clk_gen_i (
    .clk (clk),
    .rst (rst)
  );

  adder_top dut_i (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_kind  (cmd_kind),
    .cmd       (cmd),
    .res_valid (res_valid),
    .res       (res),
    .cfg       (cfg)
  );

  // rising edges seen so far
  always @(posedge clk) cyc <= cyc + 1;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_res(input string name, input adder_res_t got, input adder_res_t exp);
    if (got !== exp) begin
      $display("mismatch %s got sum=%h carry=%h ovf=%h expected sum=%h carry=%h ovf=%h",
               name, got.sum, got.carry, got.ovf, exp.sum, exp.carry, exp.ovf);
      fail_run("result compare failed");
    end
  endtask

  task automatic check_cfg(input string name, input adder_cfg_t got, input adder_cfg_t exp);
    if (got !== exp) begin
      $display("mismatch %s got %h expected %h", name, got, exp);
      fail_run("configuration compare failed");
    end
  endtask

  // 32-bit lcg, upper half is the output
  function automatic logic [15:0] lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state[31:16];
  endfunction

  function automatic adder_res_t mk_res(input logic [data_w-1:0] sum, input logic carry,
                                        input logic ovf);
    return {sum, carry, ovf};
  endfunction

  // reference model in plain integer arithmetic
  function automatic adder_res_t ref_res(input logic [data_w-1:0] a,
                                         input logic [data_w-1:0] b,
                                         input adder_cfg_t c);
    adder_res_t r;
    int ua;
    int ub;
    int sa;
    int sb;
    int cin;
    int full;
    int sfull;
    ua = a;
    ub = b;
    sa = $signed(a);
    sb = $signed(b);
    if (c.sub) begin
      full    = ua - ub;
      sfull   = sa - sb;
      // no borrow when a is not below b
      r.carry = (ua >= ub);
    end else begin
      cin     = (c.cin_en && c.carry_in) ? 1 : 0;
      full    = ua + ub + cin;
      sfull   = sa + sb + cin;
      r.carry = (full > (1 << data_w) - 1);
    end
    r.sum = full[data_w-1:0];
    r.ovf = (sfull > (1 << (data_w - 1)) - 1) || (sfull < -(1 << (data_w - 1)));
    // clamp leaves the flags alone
    if (c.sat && !c.sub && r.carry) r.sum = '1;
    if (c.sat && c.sub && !r.carry) r.sum = '0;
    return r;
  endfunction

  task automatic add_op(input logic [data_w-1:0] a, input logic [data_w-1:0] b,
                        input adder_res_t exp);
    row_t row;
    row = '0;
    row.kind = cmd_kind_op;
    row.word.ops.a = a;
    row.word.ops.b = b;
    row.exp_res = exp;
    rows.push_back(row);
  endtask

  task automatic add_cfg(input logic [cmd_w-1:0] word, input adder_cfg_t exp);
    row_t row;
    row = '0;
    row.kind = cmd_kind_cfg;
    row.word = word;
    row.exp_cfg = exp;
    rows.push_back(row);
  endtask

  // corner cases, expected cfg order is {sub, cin_en, carry_in, sat}
  task automatic build_hand_rows();
    add_op(8'h12, 8'h34, mk_res(8'h46, 1'b0, 1'b0));
    // full propagate chain from bit 0
    add_op(8'hAA, 8'h55, mk_res(8'hFF, 1'b0, 1'b0));
    add_op(8'h7F, 8'h01, mk_res(8'h80, 1'b0, 1'b1));
    add_op(8'hFF, 8'h01, mk_res(8'h00, 1'b1, 1'b0));
    add_op(8'h80, 8'h80, mk_res(8'h00, 1'b1, 1'b1));
    // carry_in without cin_en must not count
    add_cfg(16'h0008, 4'b0010);
    add_op(8'hAA, 8'h55, mk_res(8'hFF, 1'b0, 1'b0));
    add_cfg(16'h000A, 4'b0110);
    add_op(8'hAA, 8'h55, mk_res(8'h00, 1'b1, 1'b0));
    add_op(8'h7F, 8'h00, mk_res(8'h80, 1'b0, 1'b1));
    // subtract, reserved bits set and ignored
    add_cfg(16'hFFF4, 4'b1000);
    add_op(8'h50, 8'h30, mk_res(8'h20, 1'b1, 1'b0));
    add_op(8'h30, 8'h50, mk_res(8'hE0, 1'b0, 1'b0));
    add_op(8'h80, 8'h01, mk_res(8'h7F, 1'b1, 1'b1));
    add_op(8'h7F, 8'hFF, mk_res(8'h80, 1'b0, 1'b1));
    add_op(8'h00, 8'h00, mk_res(8'h00, 1'b1, 1'b0));
    // saturating subtract
    add_cfg(16'h0005, 4'b1001);
    add_op(8'h30, 8'h50, mk_res(8'h00, 1'b0, 1'b0));
    add_op(8'h50, 8'h30, mk_res(8'h20, 1'b1, 1'b0));
    // saturating add
    add_cfg(16'h0001, 4'b0001);
    add_op(8'hFF, 8'h01, mk_res(8'hFF, 1'b1, 1'b0));
    add_op(8'hC0, 8'h30, mk_res(8'hF0, 1'b0, 1'b0));
    add_op(8'h80, 8'h80, mk_res(8'hFF, 1'b1, 1'b1));
    // back to the reset setting
    add_cfg(16'h5A50, 4'b0000);
  endtask

  // random operations, a config write before about one in eight
  task automatic add_random_rows(input int count);
    logic [15:0]      r;
    logic [cmd_w-1:0] cw;
    cmd_word_u        w;
    adder_cfg_t       c;
    int               done;
    c = '0;
    done = 0;
    while (done < count) begin
      r = lcg_next();
      if (r[15:13] == 3'b000) begin
        cw = lcg_next();
        // steering bits sit at 3..0 as carry_in, sub, cin_en, sat
        c = {cw[2], cw[1], cw[3], cw[0]};
        add_cfg(cw, c);
      end
      w = lcg_next();
      add_op(w.ops.a, w.ops.b, ref_res(w.ops.a, w.ops.b, c));
      done++;
    end
  endtask

  // each pulse must match the oldest operation, two cycles after its strobe
  always @(negedge clk) begin : monitor_b
    pend_t head;
    if (!rst && res_valid) begin
      if (pend_q.size() == 0) begin
        fail_run("result pulse with no operation outstanding");
      end else begin
        head = pend_q.pop_front();
        if (cyc != head.cyc + 2) begin
          fail_run($sformatf("result in cycle %0d, strobe was in cycle %0d", cyc, head.cyc));
        end else begin
          check_res("res", res, head.res);
          n_checked++;
        end
      end
    end
  end

  initial begin : stimulus_b
    int wait_n;
    cmd_valid   = 1'b0;
    cmd_kind    = cmd_kind_op;
    cmd         = '0;
    rng_state   = 32'd38389;
    n_ops       = 0;
    n_checked   = 0;
    cfg_pending = 1'b0;
    cfg_exp     = '0;
    build_hand_rows();
    add_random_rows(200);

    wait_n = 0;
    @(negedge clk);
    while (rst !== 1'b0) begin
      if (wait_n > 16) begin
        fail_run("reset was never released");
      end else begin
        @(negedge clk);
        wait_n++;
      end
    end
    check_cfg("cfg", cfg, '0);
    check_res("res", res, '0);

    // one row per cycle, config checked on the cycle after its write
    for (int r = 0; r < rows.size(); r++) begin
      @(negedge clk);
      if (cfg_pending) check_cfg("cfg", cfg, cfg_exp);
      cfg_pending = 1'b0;
      cmd_valid   = 1'b1;
      cmd_kind    = rows[r].kind;
      cmd         = rows[r].word;
      if (rows[r].kind == cmd_kind_cfg) begin
        cfg_pending = 1'b1;
        cfg_exp     = rows[r].exp_cfg;
      end else begin
        pend_q.push_back({rows[r].exp_res, cyc});
        n_ops++;
      end
    end
    @(negedge clk);
    if (cfg_pending) check_cfg("cfg", cfg, cfg_exp);
    cmd_valid = 1'b0;

    wait_n = 0;
    while (pend_q.size() > 0) begin
      if (wait_n > 8) begin
        fail_run("results did not drain");
      end else begin
        @(negedge clk);
        wait_n++;
      end
    end
    // a few idle cycles to catch stray pulses
    repeat (3) @(negedge clk);

    if (n_checked == n_ops) begin
      $display("Simulation passed");
      $finish;
    end else begin
      fail_run($sformatf("checked %0d results for %0d operations", n_checked, n_ops));
    end
  end

endmodule

`default_nettype wire

//--- sim.f
src/adder_pkg.sv
src/pg_carry_adder.sv
src/adder_cfg_regs.sv
src/adder_stage.sv
src/adder_top.sv
dv/tb_clk_gen.sv
dv/tb_adder_top.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module tb_adder_top \
		-Mdir obj_dir -o tb_adder_top
	./obj_dir/tb_adder_top | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
